// File: verilog/mmc_pkg.sv
/* MMC SPI interface package.
   Operation codes, the widths that carry a meaning and the sclk
   divider constants shared by the CPU and card clock domains. */

package mmc_pkg;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // operations issued from the CPU side
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   typedef enum logic [2:0]
   {
      op_init,   // 80 clocks with chip select high.
      op_send,   // command frame plus one response byte.
      op_rd,
      op_wr,
      op_stop    // release chip select and clock one byte.
   } mmc_op_t;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // widths
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   typedef logic [7:0]  mmc_byte_t;
   typedef logic [47:0] mmc_cmd_t;   // six bytes, CRC byte last.
   typedef logic [5:0]  mmc_div_t;   // sclk half period in card clocks.

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // timing constants
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   localparam mmc_div_t slow_half_period = 6'd32;   // identification speed.
   localparam mmc_div_t fast_half_period = 6'd2;

   localparam int init_bytes = 10;   // ten 0xFF bytes give the 80 clocks.

endpackage

// File: verilog/mmc_spi_shift.sv
/* SPI byte shifter, mode 0, MSB first.
   Sends one byte on mmc_do and collects one from mmc_di per request,
   toggling sclk every half_period card clocks. */
`timescale 1ns/1ps

module mmc_spi_shift
(
   input  logic               clk,
   input  logic               reset,
   input  logic               byte_go,
   input  mmc_pkg::mmc_byte_t tx_byte,
   input  mmc_pkg::mmc_div_t  half_period,
   input  logic               mmc_di,
   output logic               byte_fin,
   output mmc_pkg::mmc_byte_t rx_byte,
   output logic               mmc_sclk,
   output logic               mmc_do
);
   import mmc_pkg::*;

   logic       active;
   logic       half_done;
   logic       load;
   logic [3:0] edge_cnt;   // sixteen sclk edges per byte.
   mmc_div_t   half_q;
   mmc_div_t   div_cnt;
   mmc_byte_t  tx_sr;

   assign load      = byte_go && !active;
   assign half_done = (div_cnt == half_q - 6'd1);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         active   <= 1'b0;
         byte_fin <= 1'b0;
         mmc_sclk <= 1'b0;
         mmc_do   <= 1'b1;
         div_cnt  <= '0;
         edge_cnt <= '0;
      end
      else
      begin
         byte_fin <= 1'b0;
         if (load)
         begin
            active   <= 1'b1;
            div_cnt  <= '0;
            edge_cnt <= '0;
            mmc_do   <= tx_byte[7];   // first bit is set up before the first rising edge.
         end
         else if (active && half_done)
         begin
            div_cnt  <= '0;
            mmc_sclk <= ~mmc_sclk;
            edge_cnt <= edge_cnt + 4'd1;
            if (mmc_sclk)
            begin
               mmc_do <= tx_sr[6];   // the next bit goes out on the falling edge.
               if (edge_cnt == 4'd15)
               begin
                  active   <= 1'b0;
                  byte_fin <= 1'b1;
               end
            end
         end
         else if (active)
            div_cnt <= div_cnt + 6'd1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (load)
      begin
         half_q <= half_period;
         tx_sr  <= tx_byte;
      end
      else if (active && half_done)
      begin
         if (mmc_sclk)
            tx_sr <= {tx_sr[6:0], 1'b1};   // ones fill in so mmc_do idles high.
         else
            rx_byte <= {rx_byte[6:0], mmc_di};
      end
   end

endmodule

// File: verilog/mmc_ctrl.sv
/* MMC operation controller in the card clock domain.
   Drives chip select and sequences the bytes of each operation
   through the SPI shifter, returning the last byte received. */
`timescale 1ns/1ps

module mmc_ctrl
(
   input  logic               clk,
   input  logic               reset,
   input  logic               go,
   input  mmc_pkg::mmc_op_t   op,
   input  logic               speed,
   input  mmc_pkg::mmc_cmd_t  cmd,
   input  mmc_pkg::mmc_byte_t data_in,
   input  logic               mmc_di,
   output logic               fin,
   output mmc_pkg::mmc_byte_t result,
   output logic               mmc_cs,
   output logic               mmc_sclk,
   output logic               mmc_do
);
   import mmc_pkg::*;

   typedef enum logic [2:0] {idle, init_run, cmd_run, xfer, done_st} state_t;

   state_t     state;
   logic [3:0] byte_cnt;   // bytes still to go after the current one.
   logic       byte_go;
   logic       byte_fin;
   mmc_cmd_t   cmd_sr;
   mmc_byte_t  tx_byte;
   mmc_byte_t  rx_byte;
   mmc_div_t   half_period;

   assign half_period = speed ? fast_half_period : slow_half_period;
   assign fin         = (state == done_st);

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // operation state machine
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state    <= idle;
         byte_go  <= 1'b0;
         byte_cnt <= '0;
         mmc_cs   <= 1'b1;
      end
      else
      begin
         byte_go <= 1'b0;
         case (state)
            idle:
               if (go)
               begin
                  byte_go  <= 1'b1;
                  byte_cnt <= '0;
                  case (op)
                     op_init:
                     begin
                        mmc_cs   <= 1'b1;
                        byte_cnt <= 4'(init_bytes - 1);
                        state    <= init_run;
                     end
                     op_send:
                     begin
                        mmc_cs   <= 1'b0;
                        byte_cnt <= 4'd6;   // six command bytes and the response.
                        state    <= cmd_run;
                     end
                     op_stop:
                     begin
                        mmc_cs <= 1'b1;   // cs rises before the trailing byte.
                        state  <= xfer;
                     end
                     default:
                     begin
                        mmc_cs <= 1'b0;
                        state  <= xfer;
                     end
                  endcase
               end
            init_run, cmd_run:
               if (byte_fin)
               begin
                  if (byte_cnt == 4'd0)
                     state <= done_st;
                  else
                  begin
                     byte_cnt <= byte_cnt - 4'd1;
                     byte_go  <= 1'b1;
                  end
               end
            xfer:
               if (byte_fin)
                  state <= done_st;
            default:
               state <= idle;
         endcase
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // transmit byte selection and result
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge clk)
   begin
      if (state == idle && go)
      begin
         cmd_sr <= {cmd[39:0], 8'hff};
         case (op)
            op_send: tx_byte <= cmd[47:40];
            op_wr:   tx_byte <= data_in;
            default: tx_byte <= 8'hff;
         endcase
      end
      else if (state == cmd_run && byte_fin)
      begin
         tx_byte <= cmd_sr[47:40];   // 0xFF once the command is out.
         cmd_sr  <= {cmd_sr[39:0], 8'hff};
      end
      if (byte_fin)
         result <= rx_byte;
   end

   mmc_spi_shift u_shift
   (
      .clk         (clk),
      .reset       (reset),
      .byte_go     (byte_go),
      .tx_byte     (tx_byte),
      .half_period (half_period),
      .mmc_di      (mmc_di),
      .byte_fin    (byte_fin),
      .rx_byte     (rx_byte),
      .mmc_sclk    (mmc_sclk),
      .mmc_do      (mmc_do)
   );

endmodule

// File: verilog/mmc_cdc.sv
/* Clock domain crossing between the CPU clock and the card clock.
   Toggle handshake in both directions; only the toggles are
   synchronized, the operands and the result are held stable. */
`timescale 1ns/1ps

module mmc_cdc
(
   input  logic               clk,
   input  logic               mmc_clk,
   input  logic               reset,
   input  logic               start,
   input  mmc_pkg::mmc_op_t   op,
   input  logic               speed,
   input  mmc_pkg::mmc_cmd_t  cmd,
   input  mmc_pkg::mmc_byte_t data_in,
   input  logic               fin,
   input  mmc_pkg::mmc_byte_t result,
   output logic               busy,
   output logic               done,
   output mmc_pkg::mmc_byte_t data_out,
   output logic               go,
   output mmc_pkg::mmc_op_t   held_op,
   output logic               held_speed,
   output mmc_pkg::mmc_cmd_t  held_cmd,
   output mmc_pkg::mmc_byte_t held_data
);
   import mmc_pkg::*;

   logic       accept;
   logic       req_tgl;
   logic       ack_tgl;
   logic [2:0] req_sync;   // two sync stages and the previous value.
   logic [2:0] ack_sync;
   logic       req_edge;
   logic       ack_edge;
   mmc_byte_t  res_hold;

   assign accept   = start && !busy;   // a start during an operation is dropped.
   assign req_edge = req_sync[2] ^ req_sync[1];
   assign ack_edge = ack_sync[2] ^ ack_sync[1];

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // CPU clock domain
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         req_tgl  <= 1'b0;
         busy     <= 1'b0;
         done     <= 1'b0;
         ack_sync <= '0;
      end
      else
      begin
         ack_sync <= {ack_sync[1:0], ack_tgl};
         done     <= ack_edge;
         if (accept)
         begin
            req_tgl <= ~req_tgl;
            busy    <= 1'b1;
         end
         else if (ack_edge)
            busy <= 1'b0;   // falls together with done.
      end
   end

   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         held_op    <= op;
         held_speed <= speed;
         held_cmd   <= cmd;
         held_data  <= data_in;
      end
      if (ack_edge)
         data_out <= res_hold;
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // card clock domain
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge mmc_clk)
   begin
      if (reset)
      begin
         req_sync <= '0;
         go       <= 1'b0;
         ack_tgl  <= 1'b0;
      end
      else
      begin
         req_sync <= {req_sync[1:0], req_tgl};
         go       <= req_edge;
         if (fin)
            ack_tgl <= ~ack_tgl;
      end
   end

   always_ff @(posedge mmc_clk)
   begin
      if (fin)
         res_hold <= result;   // stable well before the toggle reaches clk.
   end

endmodule

// File: verilog/mmc_wrapper.sv
/* MMC card interface top level.
   Joins the CPU side crossing to the card side controller. */
`timescale 1ns/1ps

module mmc_wrapper
(
   input  logic               clk,
   input  logic               mmc_clk,
   input  logic               reset,
   input  logic               start,
   input  mmc_pkg::mmc_op_t   op,
   input  logic               speed,
   input  mmc_pkg::mmc_cmd_t  cmd,
   input  mmc_pkg::mmc_byte_t data_in,
   input  logic               mmc_di,
   output logic               busy,
   output logic               done,
   output mmc_pkg::mmc_byte_t data_out,
   output logic               mmc_cs,
   output logic               mmc_sclk,
   output logic               mmc_do
);
   import mmc_pkg::*;

   logic      go;
   logic      fin;
   logic      held_speed;
   mmc_op_t   held_op;
   mmc_cmd_t  held_cmd;
   mmc_byte_t held_data;
   mmc_byte_t result;

   mmc_cdc u_cdc
   (
      .clk        (clk),
      .mmc_clk    (mmc_clk),
      .reset      (reset),
      .start      (start),
      .op         (op),
      .speed      (speed),
      .cmd        (cmd),
      .data_in    (data_in),
      .fin        (fin),
      .result     (result),
      .busy       (busy),
      .done       (done),
      .data_out   (data_out),
      .go         (go),
      .held_op    (held_op),
      .held_speed (held_speed),
      .held_cmd   (held_cmd),
      .held_data  (held_data)
   );

   mmc_ctrl u_ctrl
   (
      .clk      (mmc_clk),
      .reset    (reset),
      .go       (go),
      .op       (held_op),
      .speed    (held_speed),
      .cmd      (held_cmd),
      .data_in  (held_data),
      .mmc_di   (mmc_di),
      .fin      (fin),
      .result   (result),
      .mmc_cs   (mmc_cs),
      .mmc_sclk (mmc_sclk),
      .mmc_do   (mmc_do)
   );

endmodule

// File: sim/mmc_card_model.sv
/* Behavioral MMC card in SPI mode 0.
   Answers every byte with the complement of the byte it received
   before it, and keeps mmc_di high while chip select is high. */
`timescale 1ns/1ps

module mmc_card_model
(
   input  logic mmc_cs,
   input  logic mmc_sclk,
   input  logic mmc_do,
   output logic mmc_di
);
   import mmc_pkg::*;

   mmc_byte_t  rx_sr    = 8'h00;
   mmc_byte_t  last_rx  = 8'h00;
   mmc_byte_t  tx_sr    = 8'hff;   // reply to the first byte after power up.
   logic [2:0] bit_cnt  = 3'd0;
   logic       byte_end = 1'b0;

   assign mmc_di = mmc_cs ? 1'b1 : tx_sr[7];

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // receive on rising sclk
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always @(posedge mmc_sclk)
   begin
      if (!mmc_cs)
      begin
         rx_sr    <= {rx_sr[6:0], mmc_do};
         bit_cnt  <= bit_cnt + 3'd1;
         byte_end <= (bit_cnt == 3'd7);
         if (bit_cnt == 3'd7)
            last_rx <= {rx_sr[6:0], mmc_do};   // a whole byte is in.
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // transmit on falling sclk
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always @(negedge mmc_sclk)
   begin
      if (!mmc_cs)
      begin
         if (byte_end)
            tx_sr <= ~last_rx;   // the reply is ready before the next byte starts.
         else
            tx_sr <= {tx_sr[6:0], 1'b1};
      end
   end

endmodule

// File: sim/tb_mmc_wrapper.sv
/* Testbench for the MMC SPI card interface.
   Runs a table of card operations from the CPU side and checks the
   result bytes, chip select, the sclk edges and the data on mmc_do. */
`timescale 1ns/1ps

module tb_mmc_wrapper;
   import mmc_pkg::*;

   localparam int rows       = 10;
   localparam int mmc_period = 20;
   localparam int byte_clks  = (16 * int'(slow_half_period) + 1) * mmc_period / 100 + 1;

   logic        clk = 1'b0;
   logic        mmc_clk = 1'b0;
   logic        reset;
   logic        start;
   logic        speed;
   mmc_op_t     op;
   mmc_cmd_t    cmd;
   mmc_byte_t   data_in;
   mmc_byte_t   data_out;
   logic        busy;
   logic        done;
   logic        mmc_di;
   logic        mmc_cs;
   logic        mmc_sclk;
   logic        mmc_do;

   // operation table
   mmc_op_t     t_op [rows];
   logic        t_speed [rows];
   logic        t_extra [rows];   // issue a second start while busy.
   mmc_cmd_t    t_cmd [rows];
   mmc_byte_t   t_data [rows];
   mmc_byte_t   t_expect [rows];

   int          errors = 0;
   int          done_count = 0;
   int          rise_count = 0;
   int          cs_bad = 0;
   int          half_meas = 0;
   int          cycle_count = 0;
   int          timeout_limit = 0;
   logic        cs_expect;
   logic [63:0] mosi_bits = '0;
   time         rise_t = 0;

   always #50 clk = ~clk;
   always #10 mmc_clk = ~mmc_clk;

   mmc_wrapper u_mmc_wrapper
   (
      .clk      (clk),
      .mmc_clk  (mmc_clk),
      .reset    (reset),
      .start    (start),
      .op       (op),
      .speed    (speed),
      .cmd      (cmd),
      .data_in  (data_in),
      .mmc_di   (mmc_di),
      .busy     (busy),
      .done     (done),
      .data_out (data_out),
      .mmc_cs   (mmc_cs),
      .mmc_sclk (mmc_sclk),
      .mmc_do   (mmc_do)
   );

   mmc_card_model u_card
   (
      .mmc_cs   (mmc_cs),
      .mmc_sclk (mmc_sclk),
      .mmc_do   (mmc_do),
      .mmc_di   (mmc_di)
   );

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // monitors and timeout
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always @(posedge clk)
   begin
      cycle_count <= cycle_count + 1;
      if (!reset && done)
         done_count <= done_count + 1;
      if (timeout_limit > 0 && cycle_count > timeout_limit)
      begin
         $display("Timeout: no done from the DUT after %0d clk cycles.", cycle_count);
         $display("Testbench failed");
         $finish;
      end
   end

   always @(posedge mmc_sclk)
   begin
      rise_count <= rise_count + 1;
      rise_t     <= $time;
      mosi_bits  <= {mosi_bits[62:0], mmc_do};   // the card samples here too.
      if (mmc_cs !== cs_expect)
         cs_bad <= cs_bad + 1;
   end

   // high time of sclk, always exactly one half period.
   always @(negedge mmc_sclk)
      half_meas <= int'(($time - rise_t) / mmc_period);

   task automatic check_value(input string what, input logic [63:0] got,
                              input logic [63:0] expect_v);
      if (got !== expect_v)
      begin
         errors = errors + 1;
         $display("Error: time %0d ns, %s is %0h, expected %0h.", $time, what, got, expect_v);
      end
   endtask

   function automatic int op_bytes(input mmc_op_t o);
      case (o)
         op_init: return init_bytes;
         op_send: return 7;   // six command bytes and the response.
         default: return 1;
      endcase
   endfunction

   task automatic wait_done();
      do
         @(negedge clk);
      while (!done);
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // one table row
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   task automatic run_row(input int i);
      int        rise_base;
      int        cs_base;
      logic      cs_level;
      mmc_byte_t tx_last;
      cs_level  = (t_op[i] == op_init || t_op[i] == op_stop);
      tx_last   = (t_op[i] == op_wr) ? t_data[i] : 8'hff;
      rise_base = rise_count;
      cs_base   = cs_bad;
      @(posedge clk);
      cs_expect <= cs_level;
      start     <= 1'b1;
      op        <= t_op[i];
      speed     <= t_speed[i];
      cmd       <= t_cmd[i];
      data_in   <= t_data[i];
      @(posedge clk);
      start <= 1'b0;
      @(negedge clk);
      check_value("busy after start", 64'(busy), 64'(1));
      if (t_extra[i])
      begin
         @(posedge clk);
         start   <= 1'b1;
         op      <= op_wr;
         speed   <= ~t_speed[i];   // the later bytes would change speed if this were taken.
         data_in <= ~t_data[i];
         @(posedge clk);
         start <= 1'b0;
      end
      wait_done();
      check_value("data_out", 64'(data_out), 64'(t_expect[i]));
      check_value("busy with done", 64'(busy), 64'(0));
      check_value("done count", 64'(done_count), 64'(i));
      check_value("sclk rising edges", 64'(rise_count - rise_base), 64'(8 * op_bytes(t_op[i])));
      check_value("sclk edges with wrong cs", 64'(cs_bad - cs_base), 64'(0));
      check_value("mmc_cs after done", 64'(mmc_cs), 64'(cs_level));
      check_value("last byte on mmc_do", 64'(mosi_bits[7:0]), 64'(tx_last));
      if (t_op[i] == op_send)
         check_value("command on mmc_do", 64'(mosi_bits[55:8]), 64'(t_cmd[i]));
      check_value("sclk half period", 64'(half_meas),
                  t_speed[i] ? 64'(fast_half_period) : 64'(slow_half_period));
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // main sequence
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   initial
   begin
      mmc_byte_t miso_next;
      int        total_bytes;
      reset     <= 1'b1;
      start     <= 1'b0;
      op        <= op_init;
      speed     <= 1'b0;
      cmd       <= '0;
      data_in   <= '0;
      cs_expect <= 1'b1;
      void'($urandom(32'ha7d8943d));

      t_op    = '{op_init, op_send, op_wr, op_rd, op_wr, op_send, op_rd, op_stop,
                  op_send, op_stop};
      t_speed = '{1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0};
      t_extra = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};

      // expected bytes follow the card rule, starting from 0xFF.
      miso_next   = 8'hff;
      total_bytes = 0;
      for (int i = 0; i < rows; i++)
      begin
         t_cmd[i]  = {8'h40 | 8'(i), 40'({$urandom, $urandom})};
         t_data[i] = 8'($urandom);
         case (t_op[i])
            op_send:
            begin
               t_expect[i] = ~t_cmd[i][7:0];   // reply to the CRC byte.
               miso_next   = 8'h00;
            end
            op_wr:
            begin
               t_expect[i] = miso_next;
               miso_next   = ~t_data[i];
            end
            op_rd:
            begin
               t_expect[i] = miso_next;
               miso_next   = 8'h00;
            end
            default:
               t_expect[i] = 8'hff;   // chip select high, the card stays quiet.
         endcase
         total_bytes = total_bytes + op_bytes(t_op[i]);
      end
      timeout_limit = 2 * total_bytes * byte_clks;

      repeat (16) @(posedge clk);
      reset <= 1'b0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      check_value("mmc_cs after reset", 64'(mmc_cs), 64'(1));
      check_value("busy after reset", 64'(busy), 64'(0));
      check_value("done after reset", 64'(done), 64'(0));
      check_value("sclk edges after reset", 64'(rise_count), 64'(0));

      for (int i = 0; i < rows; i++)
         run_row(i);

      // no further done may follow the last operation.
      repeat (2 * byte_clks) @(posedge clk);
      @(negedge clk);
      check_value("final done count", 64'(done_count), 64'(rows));

      $display("Checks finished with %0d errors.", errors);
      if (errors == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

endmodule

// File: vlog.f
verilog/mmc_pkg.sv
verilog/mmc_spi_shift.sv
verilog/mmc_ctrl.sv
verilog/mmc_cdc.sv
verilog/mmc_wrapper.sv
sim/mmc_card_model.sv
sim/tb_mmc_wrapper.sv

// File: run_sim.sh
#!/bin/sh
# Builds the MMC SPI interface testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f vlog.f --top-module tb_mmc_wrapper -Mdir obj_dir

./obj_dir/Vtb_mmc_wrapper > sim.log
cat sim.log

if grep -q "Testbench failed" sim.log
then
   exit 1
fi
